// File: lsu_subsystem.f
source/ooo_pkg.sv
source/lsu_align.sv
source/lsu.sv
source/axi_data_ram.sv
source/lsu_subsystem.sv
bench/lsu_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the lsu_subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --timescale 1ns/1ps \
  --top-module lsu_subsystem_tb \
  -f lsu_subsystem.f \
  -o lsu_subsystem_sim

./obj_dir/lsu_subsystem_sim | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation finished without failure"
exit 0

// File: bench/lsu_subsystem_tb.sv
`default_nettype none

module lsu_subsystem_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ooo_pkg::*;

  localparam int TestBytes = 256;  // low RAM region exercised by the tests
  localparam int TestWords = TestBytes / 4;
  localparam int WaitLimit = 200;

  typedef struct packed {
    logic    is_load;
    sb_idx_t idx;
    data_t   data;
  } expect_t;

  logic     clock = 1'b0;
  logic     reset;
  lsu_req_t req;
  logic     req_valid;
  logic     req_ready;
  logic     commit_lsu;
  logic     res_valid;
  data_t    res_rdata;
  sb_idx_t  res_idx;

  logic [7:0] mirror [TestBytes];  // byte image of the RAM region
  expect_t    exp_q [$];
  expect_t    head;
  int         error_count = 0;
  int         check_count = 0;

  lsu_subsystem lsu_subsystem_inst (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .commit_lsu (commit_lsu),
    .res_valid  (res_valid),
    .res_rdata  (res_rdata),
    .res_idx    (res_idx)
  );

  always #2 clock = ~clock;

  function automatic data_t fill_word(addr_t addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c96_e10f;
  endfunction

  // expected load result built byte by byte from the mirror
  function automatic data_t expected_load(addr_t addr, size_t size, logic sext);
    logic [7:0]  base;
    logic [7:0]  b;
    logic [15:0] h;
    data_t       value;
    base = addr[7:0];
    case (size)
      2'd0: begin
        b = mirror[base];
        value = (sext && b[7]) ? {24'hff_ffff, b} : {24'h0, b};
      end
      2'd1: begin
        h = {mirror[base + 8'd1], mirror[base]};
        value = (sext && h[15]) ? {16'hffff, h} : {16'h0, h};
      end
      default: begin
        value = {mirror[base + 8'd3], mirror[base + 8'd2], mirror[base + 8'd1], mirror[base]};
      end
    endcase
    return value;
  endfunction

  function automatic void apply_store(addr_t addr, size_t size, data_t wdata);
    logic [7:0] base;
    base = addr[7:0];
    mirror[base] = wdata[7:0];
    if (size != 2'd0) begin
      mirror[base + 8'd1] = wdata[15:8];
    end
    if (size == 2'd2) begin
      mirror[base + 8'd2] = wdata[23:16];
      mirror[base + 8'd3] = wdata[31:24];
    end
  endfunction

  task automatic finish_run();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!req_ready) begin
      @(posedge clock);
      #1;
      cycles++;
      if (cycles > WaitLimit) begin
        $display("timeout at %0t: req_ready never came back high", $time);
        error_count++;
        finish_run();
      end
    end
  endtask

  // one request with commit raised delay cycles after acceptance
  task automatic issue_request(logic write, addr_t addr, size_t size, logic sext,
                               data_t wdata, sb_idx_t idx, int delay);
    expect_t e;
    wait_ready();
    req.addr   = addr;
    req.size   = size;
    req.sext   = sext;
    req.write  = write;
    req.wdata  = wdata;
    req.idx    = idx;
    req_valid  = 1'b1;
    commit_lsu = (delay == 0);
    e.is_load = !write;
    e.idx     = idx;
    e.data    = write ? '0 : expected_load(addr, size, sext);
    if (write) begin
      apply_store(addr, size, wdata);
    end
    if (delay == 0) begin
      exp_q.push_back(e);
    end
    @(posedge clock);
    #1;
    req_valid = 1'b0;
    for (int i = 0; i < delay; i++) begin
      check_count++;
      if (req_ready !== 1'b0) begin
        $display("[FAIL] %0t req_ready expected 0 got %b", $time, req_ready);
        error_count++;
      end
      if (res_valid !== 1'b0) begin
        $display("[FAIL] %0t res_valid expected 0 got %b", $time, res_valid);
        error_count++;
      end
      @(posedge clock);
      #1;
    end
    if (delay > 0) begin
      commit_lsu = 1'b1;
      exp_q.push_back(e);
    end
  endtask

  task automatic drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 || !req_ready) begin
      @(posedge clock);
      #1;
      cycles++;
      if (cycles > WaitLimit) begin
        $display("timeout at %0t: %0d results never arrived", $time, exp_q.size());
        error_count++;
        finish_run();
      end
    end
  endtask

  // results sampled mid-cycle on the falling edge
  always @(negedge clock) begin
    if (!reset && res_valid) begin
      if (exp_q.size() == 0) begin
        $display("error at %0t: result strobe with no committed request outstanding", $time);
        error_count++;
      end else begin
        head = exp_q.pop_front();
        check_count++;
        if (res_idx !== head.idx) begin
          $display("[FAIL] %0t res_idx expected %h got %h", $time, head.idx, res_idx);
          error_count++;
        end
        if (head.is_load && res_rdata !== head.data) begin
          $display("[FAIL] %0t res_rdata expected %h got %h", $time, head.data, res_rdata);
          error_count++;
        end
        // a store reports before its write response is back
        if (!head.is_load && req_ready !== 1'b0) begin
          $display("[FAIL] %0t req_ready expected 0 got %b", $time, req_ready);
          error_count++;
        end
      end
    end
  end

  initial begin
    addr_t      addr;
    size_t      size;
    logic [1:0] off;
    int         delay;
    void'($urandom(32'hdc81_b06a));
    reset      = 1'b1;
    req        = '0;
    req_valid  = 1'b0;
    commit_lsu = 1'b0;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;

    check_count++;
    if (req_ready !== 1'b1) begin
      $display("[FAIL] %0t req_ready expected 1 got %b", $time, req_ready);
      error_count++;
    end
    if (res_valid !== 1'b0) begin
      $display("[FAIL] %0t res_valid expected 0 got %b", $time, res_valid);
      error_count++;
    end

    // give the unreset RAM region known contents
    for (int w = 0; w < TestWords; w++) begin
      addr = RamBase + addr_t'(4 * w);
      issue_request(1'b1, addr, 2'd2, 1'b0, fill_word(addr), sb_idx_t'(w), 0);
    end

    addr = RamBase + 32'h40;
    issue_request(1'b1, addr, 2'd2, 1'b0, 32'hcafe_f00d, 4'd3, 0);
    issue_request(1'b0, addr, 2'd2, 1'b0, '0, 4'd9, 0);

    // narrow stores read back as whole words
    for (int o = 0; o < 4; o++) begin
      addr = RamBase + 32'h80 + addr_t'(o);
      issue_request(1'b1, addr, 2'd0, 1'b0, $urandom, sb_idx_t'(o), 0);
      issue_request(1'b0, {addr[31:2], 2'b00}, 2'd2, 1'b0, '0, sb_idx_t'(o + 4), 0);
    end
    for (int o = 0; o < 4; o += 2) begin
      addr = RamBase + 32'h90 + addr_t'(o);
      issue_request(1'b1, addr, 2'd1, 1'b0, $urandom, sb_idx_t'(o + 8), 0);
      issue_request(1'b0, {addr[31:2], 2'b00}, 2'd2, 1'b0, '0, sb_idx_t'(o + 9), 0);
    end

    // narrow loads with both signs present in each word
    issue_request(1'b1, RamBase + 32'h84, 2'd2, 1'b0, 32'h807f_ff01, 4'd1, 0);
    issue_request(1'b1, RamBase + 32'h88, 2'd2, 1'b0, 32'h7f80_01ff, 4'd2, 0);
    for (int s = 0; s < 2; s++) begin
      for (int o = 0; o < 8; o++) begin
        addr = RamBase + 32'h84 + addr_t'(o);
        issue_request(1'b0, addr, 2'd0, s[0], '0, sb_idx_t'(o), 0);
        if (o[0] == 1'b0) begin
          issue_request(1'b0, addr, 2'd1, s[0], '0, sb_idx_t'(o + 8), 0);
        end
      end
    end

    // late commit
    for (int n = 0; n < 24; n++) begin
      delay = int'($urandom_range(20, 0));
      addr = RamBase + addr_t'(4 * $urandom_range(TestWords - 1, 0));
      issue_request(n[0], addr, 2'd2, 1'b0, $urandom, sb_idx_t'(n), delay);
    end

    // random mix
    for (int n = 0; n < 300; n++) begin
      size = size_t'($urandom_range(2, 0));
      off = 2'($urandom_range(3, 0));
      if (size == 2'd1) begin
        off[0] = 1'b0;
      end else if (size == 2'd2) begin
        off = 2'b00;
      end
      addr = RamBase + addr_t'(4 * $urandom_range(TestWords - 1, 0)) + addr_t'(off);
      delay = ($urandom_range(1, 0) == 0) ? 0 : int'($urandom_range(20, 0));
      issue_request($urandom_range(1, 0) == 1, addr, size, $urandom_range(1, 0) == 1,
                    $urandom, sb_idx_t'($urandom_range(15, 0)), delay);
    end

    drain();
    finish_run();
  end

endmodule

`default_nettype wire

// File: source/lsu_subsystem.sv
`default_nettype none

module lsu_subsystem (
  input  logic              clock,
  input  logic              reset,
  input  ooo_pkg::lsu_req_t req,
  input  logic              req_valid,
  output logic              req_ready,
  input  logic              commit_lsu,
  output logic              res_valid,
  output ooo_pkg::data_t    res_rdata,
  output ooo_pkg::sb_idx_t  res_idx
);
  import ooo_pkg::*;

  // lsu to data RAM
  axi_r_m2s_t r_m2s;
  axi_r_s2m_t r_s2m;
  axi_w_m2s_t w_m2s;
  axi_w_s2m_t w_s2m;

  lsu lsu_inst (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .commit_lsu (commit_lsu),
    .res_valid  (res_valid),
    .res_rdata  (res_rdata),
    .res_idx    (res_idx),
    .r_m2s      (r_m2s),
    .r_s2m      (r_s2m),
    .w_m2s      (w_m2s),
    .w_s2m      (w_s2m)
  );

  axi_data_ram ram_inst (
    .clock (clock),
    .reset (reset),
    .r_m2s (r_m2s),
    .r_s2m (r_s2m),
    .w_m2s (w_m2s),
    .w_s2m (w_s2m)
  );

endmodule

`default_nettype wire

// File: source/axi_data_ram.sv
`default_nettype none

module axi_data_ram (
  input  logic                clock,
  input  logic                reset,
  input  ooo_pkg::axi_r_m2s_t r_m2s,
  output ooo_pkg::axi_r_s2m_t r_s2m,
  input  ooo_pkg::axi_w_m2s_t w_m2s,
  output ooo_pkg::axi_w_s2m_t w_s2m
);
  import ooo_pkg::*;

  data_t mem [RamWords];

  addr_t    rd_off;
  addr_t    wr_off;
  ram_idx_t rd_idx;
  ram_idx_t wr_idx;

  logic  ar_ready;
  logic  aw_ready;
  logic  rd_accept;
  logic  wr_accept;

  // one-deep response registers
  logic  rvalid_q;
  logic  bvalid_q;
  data_t rdata_q;

  // only the word index bits are decoded
  assign rd_off = r_m2s.araddr - RamBase;
  assign wr_off = w_m2s.awaddr - RamBase;
  assign rd_idx = rd_off[RamIndexBits+1:2];
  assign wr_idx = wr_off[RamIndexBits+1:2];

  // ready while nothing is pending
  assign ar_ready = !rvalid_q;
  assign aw_ready = !bvalid_q;

  assign rd_accept = r_m2s.arvalid && ar_ready;
  assign wr_accept = w_m2s.awvalid && w_m2s.wvalid && aw_ready;  // address and data together

  always_ff @(posedge clock) begin
    if (wr_accept) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (w_m2s.wstrb[b]) begin
          mem[wr_idx][8*b +: 8] <= w_m2s.wdata[8*b +: 8];
        end
      end
    end
    if (rd_accept) begin
      rdata_q <= mem[rd_idx];
    end
  end

  // responses are single-cycle pulses
  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_accept;
      bvalid_q <= wr_accept;
    end
  end

  always_comb begin
    r_s2m.arready = ar_ready;
    r_s2m.rvalid  = rvalid_q;
    r_s2m.rdata   = rdata_q;
    w_s2m.awready = aw_ready;
    w_s2m.wready  = aw_ready;
    w_s2m.bvalid  = bvalid_q;
  end

endmodule

`default_nettype wire

// File: source/lsu.sv
`default_nettype none

module lsu (
  input  logic                clock,
  input  logic                reset,
  input  ooo_pkg::lsu_req_t   req,
  input  logic                req_valid,
  output logic                req_ready,
  input  logic                commit_lsu,
  output logic                res_valid,
  output ooo_pkg::data_t      res_rdata,
  output ooo_pkg::sb_idx_t    res_idx,
  output ooo_pkg::axi_r_m2s_t r_m2s,
  input  ooo_pkg::axi_r_s2m_t r_s2m,
  output ooo_pkg::axi_w_m2s_t w_m2s,
  input  ooo_pkg::axi_w_s2m_t w_s2m
);
  import ooo_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_LOAD,
    WAIT_STORE,
    EXEC
  } state_t;

  state_t state;
  state_t state_next;

  logic accept;
  logic issue_load;   // read channel starts next cycle
  logic issue_store;  // write channels start next cycle
  logic load_back;
  logic done;

  data_t wr_data;
  strb_t wr_strb;
  data_t rd_value;

  // request held for the bus
  addr_t addr_q;
  size_t size_q;
  logic  sext_q;
  data_t wdata_q;
  strb_t strb_q;

  logic arvalid_q;
  logic rready_q;
  logic awvalid_q;
  logic wvalid_q;
  logic bready_q;

  assign req_ready = (state == IDLE);
  assign accept = req_valid && req_ready;

  assign issue_load = (accept && commit_lsu && !req.write)
                    || (state == WAIT_LOAD && commit_lsu);
  assign issue_store = (accept && commit_lsu && req.write)
                     || (state == WAIT_STORE && commit_lsu);

  assign load_back = (state == EXEC) && r_s2m.rvalid;
  assign done = (state == EXEC) && (r_s2m.rvalid || w_s2m.bvalid);

  lsu_align align_inst (
    .req_addr  (req.addr),
    .req_size  (req.size),
    .req_wdata (req.wdata),
    .rd_word   (r_s2m.rdata),
    .rd_offset (addr_q[1:0]),
    .rd_size   (size_q),
    .rd_sext   (sext_q),
    .wr_data   (wr_data),
    .wr_strb   (wr_strb),
    .rd_value  (rd_value)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) begin
          if (commit_lsu) begin
            state_next = EXEC;
          end else if (req.write) begin
            state_next = WAIT_STORE;
          end else begin
            state_next = WAIT_LOAD;
          end
        end
      end
      WAIT_LOAD, WAIT_STORE: begin
        if (commit_lsu) begin
          state_next = EXEC;
        end
      end
      EXEC: begin
        if (done) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  // payload, captured at acceptance
  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q  <= req.addr;
      size_q  <= req.size;
      sext_q  <= req.sext;
      wdata_q <= wr_data;
      strb_q  <= wr_strb;
      res_idx <= req.idx;
    end
    if (load_back) begin
      res_rdata <= rd_value;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      res_valid <= 1'b0;
      arvalid_q <= 1'b0;
      rready_q  <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      bready_q  <= 1'b0;
    end else begin
      // stores report on commit, loads on data
      res_valid <= issue_store || load_back;

      if (issue_load) begin
        arvalid_q <= 1'b1;
        rready_q  <= 1'b1;
      end else begin
        if (r_s2m.arready) begin
          arvalid_q <= 1'b0;
        end
        if (r_s2m.rvalid) begin
          rready_q <= 1'b0;
        end
      end

      if (issue_store) begin
        awvalid_q <= 1'b1;
        wvalid_q  <= 1'b1;
        bready_q  <= 1'b1;
      end else begin
        if (w_s2m.awready) begin
          awvalid_q <= 1'b0;
        end
        if (w_s2m.wready) begin
          wvalid_q <= 1'b0;
        end
        if (w_s2m.bvalid) begin
          bready_q <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    r_m2s.araddr  = addr_q;
    r_m2s.arsize  = {1'b0, size_q};
    r_m2s.arvalid = arvalid_q;
    r_m2s.rready  = rready_q;
    w_m2s.awaddr  = addr_q;
    w_m2s.awsize  = {1'b0, size_q};
    w_m2s.awvalid = awvalid_q;
    w_m2s.wdata   = wdata_q;  // already lane-shifted
    w_m2s.wstrb   = strb_q;
    w_m2s.wvalid  = wvalid_q;
    w_m2s.bready  = bready_q;
  end

endmodule

`default_nettype wire

// File: source/lsu_align.sv
`default_nettype none

module lsu_align (
  input  ooo_pkg::addr_t req_addr,
  input  ooo_pkg::size_t req_size,
  input  ooo_pkg::data_t req_wdata,
  input  ooo_pkg::data_t rd_word,
  input  logic [1:0]     rd_offset,
  input  ooo_pkg::size_t rd_size,
  input  logic           rd_sext,
  output ooo_pkg::data_t wr_data,
  output ooo_pkg::strb_t wr_strb,
  output ooo_pkg::data_t rd_value
);
  import ooo_pkg::*;

  strb_t strb_base;  // lane pattern before shift
  data_t rd_shifted;

  always_comb begin
    case (req_size)
      2'd0: strb_base = 4'b0001;
      2'd1: strb_base = 4'b0011;
      2'd2: strb_base = 4'b1111;
      default: strb_base = 4'b0000;  // size 3 writes nothing
    endcase
  end

  // move store data and strobe up to the addressed lane
  assign wr_strb = strb_base << req_addr[1:0];
  assign wr_data = req_wdata << {req_addr[1:0], 3'b000};

  // bring the addressed lane down to bit 0
  assign rd_shifted = rd_word >> {rd_offset, 3'b000};

  always_comb begin
    case (rd_size)
      2'd0: begin
        if (rd_sext) begin
          rd_value = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
        end else begin
          rd_value = {24'b0, rd_shifted[7:0]};
        end
      end
      2'd1: begin
        if (rd_sext) begin
          rd_value = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
        end else begin
          rd_value = {16'b0, rd_shifted[15:0]};
        end
      end
      default: rd_value = rd_shifted;  // full word
    endcase
  end

endmodule

`default_nettype wire

// File: source/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  // scoreboard and RAM geometry
  localparam int ScoreboardIndex = 4;
  localparam int RamWords = 1024;
  localparam int RamIndexBits = $clog2(RamWords);
  localparam logic [31:0] RamBase = 32'h8000_0000;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;  // one bit per byte lane
  typedef logic [1:0] size_t;  // 0 byte, 1 half, 2 word
  typedef logic [ScoreboardIndex-1:0] sb_idx_t;
  typedef logic [RamIndexBits-1:0] ram_idx_t;

  // request from execute
  typedef struct packed {
    addr_t   addr;
    size_t   size;
    logic    sext;   // 1 sign-extends byte/half loads
    logic    write;
    data_t   wdata;  // unshifted, low lanes
    sb_idx_t idx;
  } lsu_req_t;

  // read address + read data, master side
  typedef struct packed {
    addr_t      araddr;
    logic [2:0] arsize;
    logic       arvalid;
    logic       rready;
  } axi_r_m2s_t;

  typedef struct packed {
    logic  arready;
    logic  rvalid;
    data_t rdata;
  } axi_r_s2m_t;

  // write address, write data, write response
  typedef struct packed {
    addr_t      awaddr;
    logic [2:0] awsize;
    logic       awvalid;
    data_t      wdata;
    strb_t      wstrb;
    logic       wvalid;
    logic       bready;
  } axi_w_m2s_t;

  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
  } axi_w_s2m_t;

endpackage

`default_nettype wire
